//--- stack_defs.svh
`ifndef STACK_DEFS_SVH
`define STACK_DEFS_SVH

// ----------------------------------------------------------------------
// word geometry
// ----------------------------------------------------------------------
`define STACK_WIDTH       32

// ----------------------------------------------------------------------
// bank split of the 1024-word logical space
// ----------------------------------------------------------------------
`define STACK_NUMWBNK     4
`define STACK_BITWBNK     2   // upper address bits select the bank
`define STACK_NUMWROW     256
`define STACK_BITWROW     8   // lower address bits select the row
`define STACK_BITADDR     10

// read latency of one bank, counted from its read strobe
`define STACK_SRAM_DELAY  2

`endif

//--- stack_pkg.sv
`include "stack_defs.svh"

package stack_pkg;

  // one data word, also used for the per-bit write mask
  typedef logic [`STACK_WIDTH-1:0] data_t;

  // logical address as seen at the external port
  typedef logic [`STACK_BITADDR-1:0] addr_t;

  typedef logic [`STACK_BITWBNK-1:0] bank_t;
  typedef logic [`STACK_BITWROW-1:0] row_t;

  // physical address, bank on top of row
  typedef logic [`STACK_BITWBNK+`STACK_BITWROW-1:0] padr_t;

endpackage

//--- stack_cmd.sv
`timescale 1ns/1ns
`include "stack_defs.svh"

module stack_cmd (
  input  logic                                       clk,
  input  logic                                       rst,
  input  logic                                       write,
  input  stack_pkg::addr_t                           wr_adr,
  input  stack_pkg::data_t                           bw,
  input  stack_pkg::data_t                           din,
  input  logic                                       read,
  input  stack_pkg::addr_t                           rd_adr,
  output logic [`STACK_NUMWBNK-1:0]                  mem_write,
  output logic [`STACK_NUMWBNK-1:0]                  mem_read,
  output stack_pkg::row_t [`STACK_NUMWBNK-1:0]       mem_wr_adr,
  output stack_pkg::row_t [`STACK_NUMWBNK-1:0]       mem_rd_adr,
  output stack_pkg::data_t                           mem_bw,
  output stack_pkg::data_t                           mem_din,
  output logic                                       rd_issue,
  output stack_pkg::bank_t                           rd_bank,
  output stack_pkg::row_t                            rd_row,
  output logic                                       fwd_hit,
  output stack_pkg::data_t                           fwd_bw,
  output stack_pkg::data_t                           fwd_din
);
  import stack_pkg::*;

  localparam int NUMADDR = `STACK_NUMWBNK * `STACK_NUMWROW;

  bank_t wr_bank_in;
  bank_t rd_bank_in;
  row_t  wr_row_in;
  row_t  rd_row_in;

  assign wr_bank_in = wr_adr[`STACK_BITADDR-1 -: `STACK_BITWBNK];
  assign rd_bank_in = rd_adr[`STACK_BITADDR-1 -: `STACK_BITWBNK];
  assign wr_row_in  = wr_adr[`STACK_BITWROW-1:0];
  assign rd_row_in  = rd_adr[`STACK_BITWROW-1:0];

  // ----------------------------------------------------------------------
  // strobes, one-hot over the banks
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      mem_write <= '0;
      mem_read  <= '0;
      rd_issue  <= 1'b0;
      fwd_hit   <= 1'b0;
    end else begin
      for (int b = 0; b < `STACK_NUMWBNK; b++) begin
        mem_write[b] <= write && (wr_bank_in == bank_t'(b));
        mem_read[b]  <= read && (rd_bank_in == bank_t'(b));
      end
      rd_issue <= read;
      fwd_hit  <= read && write && (rd_adr == wr_adr); // same word hit in one cycle
    end
  end

  // payload, unused bank slots carry row 0
  always_ff @(posedge clk) begin
    for (int b = 0; b < `STACK_NUMWBNK; b++) begin
      mem_wr_adr[b] <= (wr_bank_in == bank_t'(b)) ? wr_row_in : '0;
      mem_rd_adr[b] <= (rd_bank_in == bank_t'(b)) ? rd_row_in : '0;
    end
    mem_bw  <= bw;
    mem_din <= din;
    rd_bank <= rd_bank_in;
    rd_row  <= rd_row_in;
    fwd_bw  <= bw;
    fwd_din <= din;
  end

  a_wr_range: assert property (@(posedge clk) disable iff (rst)
    write |-> (wr_adr < NUMADDR));
  a_rd_range: assert property (@(posedge clk) disable iff (rst)
    read |-> (rd_adr < NUMADDR));

endmodule

//--- stack_bank.sv
`timescale 1ns/1ns
`include "stack_defs.svh"

module stack_bank (
  input  logic             clk,
  input  logic             rst,
  input  logic             write,
  input  stack_pkg::row_t  wr_row,
  input  stack_pkg::data_t bw,
  input  stack_pkg::data_t din,
  input  logic             read,
  input  stack_pkg::row_t  rd_row,
  output stack_pkg::data_t rd_dout
);
  import stack_pkg::*;

  localparam int D = `STACK_SRAM_DELAY;

  data_t mem [`STACK_NUMWROW];
  data_t rd_pipe [D];

  // ----------------------------------------------------------------------
  // array and masked write
  // ----------------------------------------------------------------------
  // a read and a write to the same row in one cycle sees the old word
  always_ff @(posedge clk) begin
    if (write) begin
      mem[wr_row] <= (mem[wr_row] & ~bw) | (din & bw);
    end
  end

  // ----------------------------------------------------------------------
  // registered read pipe
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (read) begin
      rd_pipe[0] <= mem[rd_row];
    end
    for (int i = 1; i < D; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  assign rd_dout = rd_pipe[D-1];

  a_wr_row: assert property (@(posedge clk) disable iff (rst)
    write |-> (wr_row < `STACK_NUMWROW));
  a_rd_row: assert property (@(posedge clk) disable iff (rst)
    read |-> (rd_row < `STACK_NUMWROW));

endmodule

//--- stack_rdout.sv
`timescale 1ns/1ns
`include "stack_defs.svh"

module stack_rdout (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic                                   rd_issue,
  input  stack_pkg::bank_t                       rd_bank,
  input  stack_pkg::row_t                        rd_row,
  input  logic                                   fwd_hit,
  input  stack_pkg::data_t                       fwd_bw,
  input  stack_pkg::data_t                       fwd_din,
  input  stack_pkg::data_t [`STACK_NUMWBNK-1:0]  mem_rd_dout,
  output logic                                   rd_vld,
  output stack_pkg::data_t                       rd_dout,
  output logic                                   rd_fwrd,
  output stack_pkg::padr_t                       rd_padr
);
  import stack_pkg::*;

  localparam int D = `STACK_SRAM_DELAY;

  logic [D-1:0] vld_q;
  logic [D-1:0] hit_q;
  bank_t        bank_q [D];
  row_t         row_q [D];
  data_t        bw_q [D];
  data_t        din_q [D];
  data_t        bank_word;

  // ----------------------------------------------------------------------
  // read context, aligned with the bank read latency
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      vld_q <= '0;
      hit_q <= '0;
    end else begin
      vld_q <= {vld_q[D-2:0], rd_issue};
      hit_q <= {hit_q[D-2:0], fwd_hit};
    end
  end

  always_ff @(posedge clk) begin
    bank_q[0] <= rd_bank;
    row_q[0]  <= rd_row;
    bw_q[0]   <= fwd_bw;
    din_q[0]  <= fwd_din;
    for (int i = 1; i < D; i++) begin
      bank_q[i] <= bank_q[i-1];
      row_q[i]  <= row_q[i-1];
      bw_q[i]   <= bw_q[i-1];
      din_q[i]  <= din_q[i-1];
    end
  end

  assign bank_word = mem_rd_dout[bank_q[D-1]];

  // the bank returned the old word, so the colliding write is merged here
  assign rd_dout = hit_q[D-1] ? ((bank_word & ~bw_q[D-1]) | (din_q[D-1] & bw_q[D-1]))
                              : bank_word;
  assign rd_vld  = vld_q[D-1];
  assign rd_fwrd = hit_q[D-1];
  assign rd_padr = {bank_q[D-1], row_q[D-1]}; // equals the logical address

  a_vld_origin: assert property (@(posedge clk) disable iff (rst)
    rd_vld |-> $past(rd_issue, D));

endmodule

//--- stack_checker.sv
`timescale 1ns/1ns
`include "stack_defs.svh"

module stack_checker (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic                                   write,
  input  stack_pkg::addr_t                       wr_adr,
  input  stack_pkg::data_t                       bw,
  input  stack_pkg::data_t                       din,
  input  logic                                   read,
  input  stack_pkg::addr_t                       rd_adr,
  input  stack_pkg::data_t                       rd_dout,
  input  logic                                   rd_vld,
  input  logic                                   rd_fwrd,
  input  stack_pkg::padr_t                       rd_padr,
  input  stack_pkg::addr_t                       select_addr,
  input  logic [`STACK_NUMWBNK-1:0]              mem_write,
  input  stack_pkg::row_t [`STACK_NUMWBNK-1:0]   mem_wr_adr,
  input  logic [`STACK_NUMWBNK-1:0]              mem_read,
  input  stack_pkg::row_t [`STACK_NUMWBNK-1:0]   mem_rd_adr
);
  import stack_pkg::*;

  localparam int RD_LAT = `STACK_SRAM_DELAY + 1; // command flop plus bank

  data_t shadow;
  data_t shadow_def;
  data_t shadow_nxt;
  data_t def_nxt;
  logic  sel_wr;
  logic  sel_rd;

  // ----------------------------------------------------------------------
  // shadow of the selected word
  // ----------------------------------------------------------------------
  assign sel_wr = write && (wr_adr == select_addr);
  assign sel_rd = read && (rd_adr == select_addr);

  // a read in the write cycle expects the merged word
  assign shadow_nxt = sel_wr ? ((shadow & ~bw) | (din & bw)) : shadow;
  assign def_nxt    = sel_wr ? (shadow_def | bw) : shadow_def;

  always_ff @(posedge clk) begin
    if (rst) shadow_def <= '0;
    else     shadow_def <= def_nxt;
  end

  always_ff @(posedge clk) begin
    shadow <= shadow_nxt;
  end

  a_sel_data: assert property (@(posedge clk) disable iff (rst)
    sel_rd |-> ##RD_LAT (rd_vld &&
      (&(~$past(def_nxt, RD_LAT) | ~(rd_dout ^ $past(shadow_nxt, RD_LAT))))));
  a_sel_padr: assert property (@(posedge clk) disable iff (rst)
    sel_rd |-> ##RD_LAT (rd_padr == padr_t'($past(select_addr, RD_LAT))));
  a_fwrd: assert property (@(posedge clk) disable iff (rst)
    (read && write && (rd_adr == wr_adr)) |-> ##RD_LAT rd_fwrd);

  // ----------------------------------------------------------------------
  // bank side strobes
  // ----------------------------------------------------------------------
  for (genvar b = 0; b < `STACK_NUMWBNK; b++) begin : g_bank_chk
    a_mem_wr_row: assert property (@(posedge clk) disable iff (rst)
      mem_write[b] |-> (mem_wr_adr[b] < `STACK_NUMWROW));
    a_mem_rd_row: assert property (@(posedge clk) disable iff (rst)
      mem_read[b] |-> (mem_rd_adr[b] < `STACK_NUMWROW));
  end

endmodule

//--- stack_1r1w.sv
`timescale 1ns/1ns
`include "stack_defs.svh"

module stack_1r1w (
  input  logic             clk,
  input  logic             rst,
  input  logic             write,
  input  stack_pkg::addr_t wr_adr,
  input  stack_pkg::data_t bw,
  input  stack_pkg::data_t din,
  input  logic             read,
  input  stack_pkg::addr_t rd_adr,
  output logic             rd_vld,
  output stack_pkg::data_t rd_dout,
  output logic             rd_fwrd,
  output stack_pkg::padr_t rd_padr,
  input  stack_pkg::addr_t select_addr
);
  import stack_pkg::*;

  logic [`STACK_NUMWBNK-1:0]  mem_write;
  logic [`STACK_NUMWBNK-1:0]  mem_read;
  row_t [`STACK_NUMWBNK-1:0]  mem_wr_adr;
  row_t [`STACK_NUMWBNK-1:0]  mem_rd_adr;
  data_t                      mem_bw;
  data_t                      mem_din;
  data_t [`STACK_NUMWBNK-1:0] mem_rd_dout;
  logic                       rd_issue;
  bank_t                      rd_bank;
  row_t                       rd_row;
  logic                       fwd_hit;
  data_t                      fwd_bw;
  data_t                      fwd_din;

  stack_cmd u_cmd (
    .clk, .rst, .write, .wr_adr, .bw, .din, .read, .rd_adr,
    .mem_write, .mem_read, .mem_wr_adr, .mem_rd_adr, .mem_bw, .mem_din,
    .rd_issue, .rd_bank, .rd_row, .fwd_hit, .fwd_bw, .fwd_din
  );

  // ----------------------------------------------------------------------
  // banks
  // ----------------------------------------------------------------------
  for (genvar k = 0; k < `STACK_NUMWBNK; k++) begin : g_bank
    data_t mem_rd_dout_k;

    stack_bank u_bank (
      .clk, .rst,
      .write   (mem_write[k]),
      .wr_row  (mem_wr_adr[k]),
      .bw      (mem_bw),      // mask and data go to every bank
      .din     (mem_din),
      .read    (mem_read[k]),
      .rd_row  (mem_rd_adr[k]),
      .rd_dout (mem_rd_dout_k)
    );

    assign mem_rd_dout[k] = mem_rd_dout_k;
  end

  stack_rdout u_rdout (
    .clk, .rst, .rd_issue, .rd_bank, .rd_row, .fwd_hit, .fwd_bw, .fwd_din,
    .mem_rd_dout, .rd_vld, .rd_dout, .rd_fwrd, .rd_padr
  );

  stack_checker u_checker (
    .clk, .rst, .write, .wr_adr, .bw, .din, .read, .rd_adr,
    .rd_dout, .rd_vld, .rd_fwrd, .rd_padr, .select_addr,
    .mem_write, .mem_wr_adr, .mem_read, .mem_rd_adr
  );

endmodule

//--- tb_stack_1r1w.sv
`timescale 1ns/1ns
`include "stack_defs.svh"

module tb_stack_1r1w;
  import stack_pkg::*;

  localparam int RD_LAT   = `STACK_SRAM_DELAY + 1; // command flop plus bank pipe
  localparam int NUMADDR  = `STACK_NUMWBNK * `STACK_NUMWROW;
  localparam int DRAIN_TO = 20;

  logic   clk;
  logic   rst;
  logic   write;
  addr_t  wr_adr;
  data_t  bw;
  data_t  din;
  logic   read;
  addr_t  rd_adr;
  addr_t  select_addr;
  logic   rd_vld;
  data_t  rd_dout;
  logic   rd_fwrd;
  padr_t  rd_padr;

  data_t  ref_mem [NUMADDR];
  data_t  exp_data_q [$];
  addr_t  exp_adr_q [$];
  logic   exp_fwd_q [$];
  int     exp_cyc_q [$];
  int     cyc = 0;
  int     data_errs = 0;
  int     proto_errs = 0;
  integer seed;
  data_t  e_data;
  addr_t  e_adr;
  logic   e_fwd;

  stack_1r1w u_stack_1r1w (
    .clk, .rst, .write, .wr_adr, .bw, .din, .read, .rd_adr,
    .rd_vld, .rd_dout, .rd_fwrd, .rd_padr, .select_addr
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  // ----------------------------------------------------------------------
  // reference model
  // ----------------------------------------------------------------------
  function automatic data_t merge_word(data_t old, data_t m, data_t d);
    return (old & ~m) | (d & m); // masked-off bits keep the old value
  endfunction

  // a write in the same cycle as the read is merged into the returned word
  function automatic data_t predict_read(addr_t ra, logic we, addr_t wa, data_t m, data_t d);
    data_t w;
    w = ref_mem[ra];
    if (we && (wa == ra)) w = merge_word(w, m, d);
    return w;
  endfunction

  function automatic data_t fill_word(addr_t a);
    return {a, a[5:0], 6'h2d, ~a} ^ 32'h5a3c_96e1;
  endfunction

  task automatic drive(input logic we, input addr_t wa, input data_t m, input data_t d,
                       input logic re, input addr_t ra);
    @(negedge clk);
    write  = we;
    wr_adr = wa;
    bw     = m;
    din    = d;
    read   = re;
    rd_adr = ra;
    if (re) begin
      exp_data_q.push_back(predict_read(ra, we, wa, m, d));
      exp_adr_q.push_back(ra);
      exp_fwd_q.push_back(we && (wa == ra));
      exp_cyc_q.push_back(cyc + RD_LAT);
    end
    if (we) ref_mem[wa] = merge_word(ref_mem[wa], m, d);
  endtask

  task automatic idle(input int n);
    for (int i = 0; i < n; i++) drive(1'b0, '0, '0, '0, 1'b0, '0);
  endtask

  // ----------------------------------------------------------------------
  // compare process, outputs are stable at the falling edge
  // ----------------------------------------------------------------------
  always @(negedge clk) begin
    if (!rst && exp_cyc_q.size() > 0 && exp_cyc_q[0] == cyc) begin
      e_data = exp_data_q.pop_front();
      e_adr  = exp_adr_q.pop_front();
      e_fwd  = exp_fwd_q.pop_front();
      void'(exp_cyc_q.pop_front());
      assert (rd_vld === 1'b1) else begin
        proto_errs++;
        $display("rd_vld did not rise for the read of %h at %0t", e_adr, $time);
      end
      assert (rd_dout === e_data) else begin
        data_errs++;
        $display("mismatch at %0t: rd_dout %h for %h, expected %h", $time, rd_dout, e_adr, e_data);
      end
      assert (rd_fwrd === e_fwd) else begin
        data_errs++;
        $display("mismatch at %0t: rd_fwrd %b for %h, expected %b", $time, rd_fwrd, e_adr, e_fwd);
      end
      assert (rd_padr === padr_t'(e_adr)) else begin
        data_errs++;
        $display("mismatch at %0t: rd_padr %h, expected %h", $time, rd_padr, e_adr);
      end
    end else if (!rst) begin
      assert (rd_vld === 1'b0 && rd_fwrd === 1'b0) else begin
        proto_errs++;
        $display("rd_vld or rd_fwrd high at %0t with no read due", $time);
      end
    end
  end

  // ----------------------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------------------
  initial begin
    integer r;
    logic   we;
    logic   re;
    addr_t  wa;
    addr_t  ra;
    data_t  m;
    data_t  d;
    int     n;

    seed        = 32'hd263;
    rst         = 1'b1;
    write       = 1'b0;
    wr_adr      = '0;
    bw          = '0;
    din         = '0;
    read        = 1'b0;
    rd_adr      = '0;
    select_addr = 10'h2a7; // word hit by the partial-mask test
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    idle(8); // nothing issued, so no rd_vld expected

    // every word gets a full-mask write, then all are read back to back
    for (int i = 0; i < NUMADDR; i++) drive(1'b1, addr_t'(i), '1, fill_word(addr_t'(i)), 1'b0, '0);
    for (int i = 0; i < NUMADDR; i++) drive(1'b0, '0, '0, '0, 1'b1, addr_t'(i));

    drive(1'b1, 10'h2a7, 32'h0000_ffff, 32'hcafe_f00d, 1'b0, '0);
    drive(1'b0, '0, '0, '0, 1'b1, 10'h2a7);

    // same-cycle collisions, then one to a different address in another bank
    drive(1'b1, 10'h1c3, 32'hff00_ff00, 32'h1234_5678, 1'b1, 10'h1c3);
    drive(1'b0, '0, '0, '0, 1'b1, 10'h1c3);
    drive(1'b1, 10'h0c3, '1, 32'h8765_4321, 1'b1, 10'h3c3);
    drive(1'b0, '0, '0, '0, 1'b1, 10'h0c3);
    idle(4);

    for (int i = 0; i < 2000; i++) begin
      r  = $random(seed);
      we = r[0];
      re = r[1];
      wa = addr_t'($random(seed));
      ra = addr_t'($random(seed));
      if (r[3:2] == 2'b00) ra = wa;   // keep collisions frequent
      m  = $random(seed);
      if (r[4]) m = '1;
      d  = $random(seed);
      drive(we, wa, m, d, re, ra);
    end
    idle(1);

    n = 0;
    while (exp_cyc_q.size() > 0 && n < DRAIN_TO) begin
      @(negedge clk);
      n++;
    end
    if (exp_cyc_q.size() > 0) begin
      proto_errs++;
      $display("timeout with %0d reads still waiting for rd_vld", exp_cyc_q.size());
    end
    idle(4);

    $display("errors: data %0d, protocol %0d", data_errs, proto_errs);
    if (data_errs == 0 && proto_errs == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+.
stack_pkg.sv
stack_cmd.sv
stack_bank.sv
stack_rdout.sv
stack_checker.sv
stack_1r1w.sv
tb_stack_1r1w.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f vlog.f --top-module tb_stack_1r1w -o sim_stack \
  && ./obj_dir/sim_stack > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^Everything OK$" sim.log \
  && echo "PASS" && exit 0 \
  || { echo "FAIL"; exit 1; }
